//--- dma_sys.f
verilog/dma_pkg.sv
verilog/dma_fifo.sv
verilog/dram_port.sv
verilog/dma_ctrl.sv
verilog/dma_sys.sv
verif/dma_sys_checker.sv
verif/dma_sys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the dma testbench with verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f dma_sys.f --top-module dma_sys_tb -o dma_sys_sim \
    && ./obj_dir/dma_sys_sim | tee /dev/stderr | grep -x "TEST PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verif/dma_sys_tb.sv
// random-setup testbench with sparse memory, IDE and CRAM models
// expected accesses of a transfer are built before its launch
`timescale 1ns/1ps

module dma_sys_tb
    import dma_pkg::*;
();

    logic                clk = 1'b0;
    logic                rst_n;
    logic [strb_cnt-1:0] port_wr;
    logic [7:0]          zdata;
    logic                dma_act;
    logic [data_w-1:0]   ide_in;
    logic [data_w-1:0]   ide_out;
    logic                ide_req;
    logic                ide_rnw;
    logic                ide_stb;
    logic                cram_we;
    logic [data_w-1:0]   cram_data;
    logic [7:0]          wraddr;
    logic                mem_valid;
    logic                mem_ready;
    logic [addr_w-1:0]   mem_addr;
    logic                mem_we;
    logic [data_w-1:0]   mem_wdata;
    logic                mem_rvalid;
    logic [data_w-1:0]   mem_rdata;

    int    errors = 0;
    int    cyc = 0;
    int    deadline = 1000;
    int    ide_dly = 0;
    string test_name = "reset";

    logic [data_w-1:0] dut_mem [logic [addr_w-1:0]];
    logic [data_w-1:0] ref_mem [logic [addr_w-1:0]];
    logic [addr_w-1:0] exp_rd_addr [$];
    logic [addr_w-1:0] exp_wr_addr [$];
    logic [data_w-1:0] exp_wr_data [$];
    logic [data_w-1:0] exp_ide [$];
    logic [data_w-1:0] ide_src [$];
    logic [7:0]        exp_cram_addr [$];
    logic [data_w-1:0] exp_cram_data [$];
    int                rsp_due [$];
    logic [data_w-1:0] rsp_data [$];

    // model copy of the setup registers
    logic [addr_w-1:0] m_saddr;
    logic [addr_w-1:0] m_daddr;
    logic [7:0]        m_slow;
    logic [7:0]        m_dlow;
    logic [7:0]        m_len;
    logic [7:0]        m_num;

    dma_sys dma_sys_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .port_wr    (port_wr),
        .zdata      (zdata),
        .dma_act    (dma_act),
        .ide_in     (ide_in),
        .ide_out    (ide_out),
        .ide_req    (ide_req),
        .ide_rnw    (ide_rnw),
        .ide_stb    (ide_stb),
        .cram_we    (cram_we),
        .cram_data  (cram_data),
        .wraddr     (wraddr),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_addr   (mem_addr),
        .mem_we     (mem_we),
        .mem_wdata  (mem_wdata),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Mismatch %s %s expected %0h actual %0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    // contents of a never written word
    function automatic logic [data_w-1:0] fill_word(logic [addr_w-1:0] a);
        return a[15:0] ^ {a[20:16], a[20:10]} ^ 16'h3c5a;
    endfunction

    // linear step, or line stepping with the saved low bits at a burst end
    function automatic logic [addr_w-1:0] next_addr(logic [addr_w-1:0] a, logic [7:0] low,
                                                    logic algn, logic asz, logic last);
        if (!algn)
            return a + 21'd1;
        if (asz)
            return last ? {a[20:8] + 13'd1, low} : {a[20:8], a[7:0] + 8'd1};
        return last ? {a[20:7] + 14'd1, low[6:0]} : {a[20:7], a[6:0] + 7'd1};
    endfunction

    // memory channel with random ready and 1 to 3 cycles of read latency
    always @(posedge clk)
    begin
        int due;
        mem_rvalid <= 1'b0;
        if (rsp_due.size() != 0 && cyc >= rsp_due[0])
        begin
            mem_rvalid <= 1'b1;
            mem_rdata  <= rsp_data.pop_front();
            void'(rsp_due.pop_front());
        end
        if (mem_valid && mem_ready)
        begin
            if (mem_we)
            begin
                if (exp_wr_addr.size() == 0)
                begin
                    $display("unexpected memory write to address %0h", mem_addr);
                    errors++;
                end
                else
                begin
                    check_value("wr_addr", exp_wr_addr.pop_front(), mem_addr);
                    check_value("wr_data", exp_wr_data.pop_front(), mem_wdata);
                end
                dut_mem[mem_addr] = mem_wdata;
            end
            else
            begin
                if (exp_rd_addr.size() == 0)
                begin
                    $display("unexpected memory read from address %0h", mem_addr);
                    errors++;
                end
                else
                    check_value("rd_addr", exp_rd_addr.pop_front(), mem_addr);
                due = cyc + 1 + int'($urandom % 3);
                if (rsp_due.size() != 0 && due <= rsp_due[$])
                    due = rsp_due[$] + 1;
                rsp_due.push_back(due);
                rsp_data.push_back(dut_mem.exists(mem_addr) ? dut_mem[mem_addr]
                                                           : fill_word(mem_addr));
            end
        end
        mem_ready <= ($urandom % 4) != 0;
    end

    // IDE device strobing after a random wait
    always @(posedge clk)
    begin
        if (ide_stb)
        begin
            ide_stb <= 1'b0;
            ide_dly <= $urandom % 4;
        end
        else if (ide_req)
        begin
            if (ide_dly != 0)
                ide_dly <= ide_dly - 1;
            else
            begin
                ide_stb <= 1'b1;
                if (ide_rnw && ide_src.size() != 0)
                    ide_in <= ide_src.pop_front();
                else if (!ide_rnw && exp_ide.size() != 0)
                    check_value("ide_out", exp_ide.pop_front(), ide_out);
                else
                begin
                    $display("IDE access with no word planned");
                    errors++;
                end
            end
        end
    end

    always @(posedge clk)
    begin
        if (cram_we)
        begin
            if (exp_cram_data.size() == 0)
            begin
                $display("unexpected CRAM write at %0h", wraddr);
                errors++;
            end
            else
            begin
                check_value("wraddr", exp_cram_addr.pop_front(), wraddr);
                check_value("cram_data", exp_cram_data.pop_front(), cram_data);
            end
        end
    end

    always @(posedge clk)
    begin
        if (cyc > deadline)
        begin
            $display("watchdog expired at cycle %0d, transfer never finished", cyc);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic write_reg(int idx, logic [7:0] val);
        @(posedge clk);
        port_wr <= strb_cnt'(1) << idx;
        zdata   <= val;
        @(posedge clk);
        port_wr <= '0;
    endtask

    task automatic set_addr(int base, logic [addr_w-1:0] a);
        write_reg(base, {a[6:0], 1'b0});
        write_reg(base + 1, {2'b00, a[12:7]});
        write_reg(base + 2, a[20:13]);
    endtask

    task automatic setup(logic [addr_w-1:0] src, logic [addr_w-1:0] dst,
                         logic [7:0] len, logic [7:0] num);
        deadline = cyc + 1000;
        set_addr(strb_saddr_l, src);
        set_addr(strb_daddr_l, dst);
        write_reg(strb_len, len);
        write_reg(strb_num, num);
        m_saddr = src;
        m_slow  = src[7:0];
        m_daddr = dst;
        m_dlow  = dst[7:0];
        m_len   = len;
        m_num   = num;
    endtask

    // reference model with one read and one write per word in order
    task automatic build_expect(logic [7:0] ctrl);
        logic [2:0]        dev;
        logic              wnr;
        logic              last;
        logic [data_w-1:0] w;
        dev = ctrl[2:0];
        wnr = ctrl[ctrl_wnr_bit];
        for (int b = 0; b <= int'(m_num); b++)
        begin
            for (int j = 0; j <= int'(m_len); j++)
            begin
                last = (j == int'(m_len));
                if (dev == dev_ram || wnr)
                begin
                    exp_rd_addr.push_back(m_saddr);
                    w = ref_mem.exists(m_saddr) ? ref_mem[m_saddr] : fill_word(m_saddr);
                end
                else
                begin
                    w = data_w'($urandom);
                    ide_src.push_back(w);
                end
                m_saddr = next_addr(m_saddr, m_slow, ctrl[ctrl_salgn_bit],
                                    ctrl[ctrl_asz_bit], last);
                if (dev == dev_ram || !wnr)
                begin
                    exp_wr_addr.push_back(m_daddr);
                    exp_wr_data.push_back(w);
                    ref_mem[m_daddr] = w;
                end
                else if (dev == dev_ide)
                    exp_ide.push_back(w);
                else
                begin
                    exp_cram_addr.push_back(m_daddr[7:0]);
                    exp_cram_data.push_back(w);
                end
                m_daddr = next_addr(m_daddr, m_dlow, ctrl[ctrl_dalgn_bit],
                                    ctrl[ctrl_asz_bit], last);
            end
        end
    endtask

    task automatic run_transfer(logic [7:0] ctrl, bit disturb);
        build_expect(ctrl);
        deadline = cyc + 200 * (int'(m_len) + 1) * (int'(m_num) + 1) + 1000;
        write_reg(strb_launch, ctrl);
        @(posedge clk);
        check_value("act_rise", 1, dma_act);
        // setup writes into a running transfer
        if (disturb)
        begin
            repeat (6)
            begin
                port_wr <= strb_cnt'(1) << ($urandom % strb_cnt);
                zdata   <= 8'($urandom);
                @(posedge clk);
            end
            port_wr <= '0;
        end
        while (dma_act)
            @(posedge clk);
        while (exp_wr_addr.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        check_value("reads_left", 0, exp_rd_addr.size());
        check_value("ide_left", 0, exp_ide.size() + ide_src.size());
        check_value("cram_left", 0, exp_cram_data.size());
    endtask

    initial
    begin
        void'($urandom(32'hf0e9_87a2));
        rst_n      = 1'b0;
        port_wr    = '0;
        zdata      = '0;
        ide_in     = '0;
        ide_stb    = 1'b0;
        mem_ready  = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        repeat (8)
        begin
            @(posedge clk);
            check_value("quiet", 0, {dma_act, mem_valid, ide_req, cram_we});
        end

        test_name = "ram_linear";
        repeat (4)
        begin
            setup(21'($urandom), 21'($urandom), 8'($urandom % 16), 8'($urandom % 8));
            run_transfer({5'b00000, dev_ram}, 0);
        end

        // mode bit 1 aligns the source, bit 0 the destination
        test_name = "ram_aligned";
        for (int asz = 0; asz < 2; asz++)
        begin
            for (int mode = 1; mode < 4; mode++)
            begin
                setup(21'($urandom), 21'($urandom), 8'($urandom % 16), 8'(1 + $urandom % 7));
                run_transfer({2'b00, mode[1], mode[0], asz[0], dev_ram}, 0);
            end
        end

        test_name = "ide_read";
        repeat (2)
        begin
            setup(21'($urandom), 21'($urandom), 8'($urandom % 8), 8'($urandom % 4));
            run_transfer({5'b00000, dev_ide}, 0);
        end

        test_name = "ide_write";
        repeat (2)
        begin
            setup(21'($urandom), 21'($urandom), 8'($urandom % 8), 8'($urandom % 4));
            run_transfer({5'b10000, dev_ide}, 0);
        end

        test_name = "cram";
        repeat (2)
        begin
            setup(21'($urandom), 21'($urandom), 8'($urandom % 16), 8'($urandom % 4));
            run_transfer({5'b10010, dev_cram}, 0);
        end

        // the second launch reuses the setup left by the first
        test_name = "locked_setup";
        setup(21'($urandom), 21'($urandom), 8'd7, 8'd3);
        run_transfer({5'b00000, dev_ram}, 1);
        run_transfer({5'b00000, dev_ram}, 0);

        repeat (4) @(posedge clk);
        $display("all tests done, %0d error(s)", errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- verif/dma_sys_checker.sv
// handshake and reset checks, bound into the dma top level
// needs a simulator run with assertions enabled
`timescale 1ns/1ps

module dma_sys_checker
    import dma_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              req_valid,
    input logic              req_ready,
    input dram_req_t         req_data,
    input logic              mem_valid,
    input logic              mem_ready,
    input logic [addr_w-1:0] mem_addr,
    input logic              mem_we,
    input logic [data_w-1:0] mem_wdata,
    input logic              dma_act,
    input logic              ide_req,
    input logic              cram_we
);

    // a stalled request keeps valid and payload
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req_data))
        else $error("request channel dropped valid or changed data while stalled");

    mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && !mem_ready |=> mem_valid && $stable({mem_addr, mem_we, mem_wdata}))
        else $error("memory channel dropped valid or changed data while stalled");

    // nothing active right after reset
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !dma_act && !mem_valid && !ide_req && !cram_we)
        else $error("engine outputs active in the cycle after reset");

endmodule

bind dma_sys dma_sys_checker dma_sys_checker_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_data  (req_data),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .mem_we    (mem_we),
    .mem_wdata (mem_wdata),
    .dma_act   (dma_act),
    .ide_req   (ide_req),
    .cram_we   (cram_we)
);

//--- verilog/dma_sys.sv
// dma engine top: controller, request and read-data fifos, memory port
// memory must answer each accepted read with exactly one mem_rvalid
`timescale 1ns/1ps

module dma_sys
    import dma_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [strb_cnt-1:0] port_wr,
    input  logic [7:0]          zdata,
    output logic                dma_act,
    input  logic [data_w-1:0]   ide_in,
    output logic [data_w-1:0]   ide_out,
    output logic                ide_req,
    output logic                ide_rnw,
    input  logic                ide_stb,
    output logic                cram_we,
    output logic [data_w-1:0]   cram_data,
    output logic [7:0]          wraddr,
    output logic                mem_valid,
    input  logic                mem_ready,
    output logic [addr_w-1:0]   mem_addr,
    output logic                mem_we,
    output logic [data_w-1:0]   mem_wdata,
    input  logic                mem_rvalid,
    input  logic [data_w-1:0]   mem_rdata
);

    // controller to request fifo
    logic                  req_valid;
    logic                  req_ready;
    dram_req_t             req_data;
    // request fifo to memory port
    logic                  q_req_valid;
    logic                  q_req_ready;
    dram_req_t             q_req_data;
    // memory port to read fifo
    logic                  rd_in_valid;
    logic                  rd_in_ready;
    logic [data_w-1:0]     rd_in_data;
    // read fifo to controller
    logic                  rd_valid;
    logic                  rd_ready;
    logic [data_w-1:0]     rd_data;
    logic [fifo_cnt_w-1:0] rd_used;
    logic [fifo_cnt_w-1:0] rd_space;

    // read fifo fill level, feeds the read credit of the memory port
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            rd_used <= '0;
        else if ((rd_in_valid && rd_in_ready) && !(rd_valid && rd_ready))
            rd_used <= rd_used + 1'b1;
        else if ((rd_valid && rd_ready) && !(rd_in_valid && rd_in_ready))
            rd_used <= rd_used - 1'b1;
    end

    assign rd_space = fifo_cnt_w'(fifo_depth) - rd_used;

    dma_ctrl dma_ctrl_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .port_wr   (port_wr),
        .zdata     (zdata),
        .dma_act   (dma_act),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_data  (req_data),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_data   (rd_data),
        .ide_in    (ide_in),
        .ide_out   (ide_out),
        .ide_req   (ide_req),
        .ide_rnw   (ide_rnw),
        .ide_stb   (ide_stb),
        .cram_we   (cram_we),
        .cram_data (cram_data),
        .wraddr    (wraddr)
    );

    dma_fifo #(.payload_t(dram_req_t)) req_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req_data),
        .out_valid (q_req_valid),
        .out_ready (q_req_ready),
        .out_data  (q_req_data)
    );

    dram_port dram_port_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (q_req_valid),
        .req_ready  (q_req_ready),
        .req_data   (q_req_data),
        .rd_space   (rd_space),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_addr   (mem_addr),
        .mem_we     (mem_we),
        .mem_wdata  (mem_wdata),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .rd_valid   (rd_in_valid),
        .rd_data    (rd_in_data)
    );

    dma_fifo #(.payload_t(logic [data_w-1:0])) rd_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (rd_in_valid),
        .in_ready  (rd_in_ready),
        .in_data   (rd_in_data),
        .out_valid (rd_valid),
        .out_ready (rd_ready),
        .out_data  (rd_data)
    );

endmodule

//--- verilog/dma_ctrl.sv
// dma sequencer: one word in flight, read phase then write phase
// device codes other than RAM, IDE and CRAM (write only) stall the transfer
`timescale 1ns/1ps

module dma_ctrl
    import dma_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [strb_cnt-1:0] port_wr,
    input  logic [7:0]          zdata,
    output logic                dma_act,
    output logic                req_valid,
    input  logic                req_ready,
    output dram_req_t           req_data,
    input  logic                rd_valid,
    output logic                rd_ready,
    input  logic [data_w-1:0]   rd_data,
    input  logic [data_w-1:0]   ide_in,
    output logic [data_w-1:0]   ide_out,
    output logic                ide_req,
    output logic                ide_rnw,
    input  logic                ide_stb,
    output logic                cram_we,
    output logic [data_w-1:0]   cram_data,
    output logic [7:0]          wraddr
);

    logic [strb_cnt-1:0] wr_en;
    logic [2:0]          device;
    logic                ctl_wnr;
    logic                ctl_salgn;
    logic                ctl_dalgn;
    logic                ctl_asz;
    logic                phase;
    logic                req_sent;
    logic [7:0]          b_len;
    logic [7:0]          b_num;
    logic [7:0]          b_ctr;
    logic [8:0]          n_ctr;
    logic [8:0]          b_ctr_dec;
    logic                next_burst;
    logic [addr_w-1:0]   s_addr;
    logic [addr_w-1:0]   d_addr;
    logic [7:0]          s_low;
    logic [7:0]          d_low;
    logic [data_w-1:0]   data;
    logic                dv_ram;
    logic                dv_ide;
    logic                dv_crm;
    logic                state_rd;
    logic                state_wr;
    logic                state_mem;
    logic                state_dev;
    logic                req_xfer;
    logic                rd_xfer;
    logic                dev_stb;
    logic                phase_end;
    logic                cyc_end;

    // next word address; aligned mode restores the low byte and steps one line
    function automatic logic [addr_w-1:0] addr_step(
        input logic [addr_w-1:0] addr,
        input logic [7:0]        low,
        input logic              algn,
        input logic              asz,
        input logic              brst
    );
        logic [8:0]  inc_l;
        logic [7:0]  nxt_l;
        logic [1:0]  add_h;
        logic [13:0] nxt_h;
        logic        nxt_m;
        inc_l = {1'b0, addr[7:0]} + 9'd1;
        nxt_l = (algn && brst) ? low : inc_l[7:0];
        add_h = algn ? {brst && asz, brst && !asz} : {inc_l[8], 1'b0};
        nxt_h = addr[addr_w-1:7] + {12'd0, add_h};
        // bit 7 comes from the saved byte for 256-word lines
        nxt_m = algn ? (asz ? nxt_l[7] : nxt_h[0]) : inc_l[7];
        return {nxt_h[13:1], nxt_m, nxt_l[6:0]};
    endfunction

    // setup is locked while a transfer runs
    assign wr_en = port_wr & {strb_cnt{!dma_act}};

    assign dv_ram = (device == dev_ram);
    assign dv_ide = (device == dev_ide);
    assign dv_crm = (device == dev_cram) && ctl_wnr;

    assign state_rd  = !phase;
    assign state_wr  = phase;
    assign state_mem = dv_ram || (ctl_wnr ^ phase);
    assign state_dev = !dv_ram && (ctl_wnr ^ !phase);

    assign dma_act = !n_ctr[8];

    // device side
    assign ide_req   = dma_act && state_dev && dv_ide;
    assign ide_rnw   = state_rd;
    assign ide_out   = data;
    assign cram_we   = dma_act && state_dev && state_wr && dv_crm;
    assign cram_data = data;
    assign wraddr    = d_addr[7:0];
    assign dev_stb   = cram_we || (ide_req && ide_stb);

    // memory side, a single request per phase
    assign req_valid = dma_act && state_mem && !req_sent;
    assign req_xfer  = req_valid && req_ready;
    assign req_data  = '{addr: state_rd ? s_addr : d_addr, we: state_wr, wdata: data};
    assign rd_ready  = dma_act && state_mem && state_rd && req_sent;
    assign rd_xfer   = rd_valid && rd_ready;

    assign phase_end = state_mem ? (state_rd ? rd_xfer : req_xfer) : dev_stb;
    assign cyc_end   = state_wr && phase_end;

    assign b_ctr_dec  = {1'b0, b_ctr} - 9'd1;
    assign next_burst = b_ctr_dec[8];

    // control byte and phase
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            device    <= '0;
            ctl_wnr   <= 1'b0;
            ctl_salgn <= 1'b0;
            ctl_dalgn <= 1'b0;
            ctl_asz   <= 1'b0;
            phase     <= 1'b0;
        end
        else if (wr_en[strb_launch])
        begin
            device    <= zdata[2:0];
            ctl_wnr   <= zdata[ctrl_wnr_bit];
            ctl_salgn <= zdata[ctrl_salgn_bit];
            ctl_dalgn <= zdata[ctrl_dalgn_bit];
            ctl_asz   <= zdata[ctrl_asz_bit];
            phase     <= 1'b0;
        end
        else if (phase_end)
        begin
            phase <= !phase;
        end
    end

    // read request issued, now waiting for its data
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            req_sent <= 1'b0;
        else if (phase_end)
            req_sent <= 1'b0;
        else if (req_xfer)
            req_sent <= 1'b1;
    end

    // word and burst counters, n_ctr underflow ends the transfer
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            n_ctr <= 9'h100;
        end
        else if (wr_en[strb_launch])
        begin
            b_ctr <= b_len;
            n_ctr <= {1'b0, b_num};
        end
        else if (cyc_end)
        begin
            b_ctr <= next_burst ? b_len : b_ctr_dec[7:0];
            n_ctr <= n_ctr - {8'd0, next_burst};
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en[strb_len])
            b_len <= zdata;
        if (wr_en[strb_num])
            b_num <= zdata;
    end

    always_ff @(posedge clk)
    begin
        if (state_rd && phase_end)
            data <= state_mem ? rd_data : ide_in;
    end

    // source address
    always_ff @(posedge clk)
    begin
        if (state_rd && phase_end)
        begin
            s_addr <= addr_step(s_addr, s_low, ctl_salgn, ctl_asz, next_burst);
        end
        else
        begin
            if (wr_en[strb_saddr_l])
            begin
                s_addr[6:0] <= zdata[7:1];
                s_low[6:0]  <= zdata[7:1];
            end
            if (wr_en[strb_saddr_h])
            begin
                s_addr[12:7] <= zdata[5:0];
                s_low[7]     <= zdata[0];
            end
            if (wr_en[strb_saddr_x])
                s_addr[20:13] <= zdata;
        end
    end

    // destination address
    always_ff @(posedge clk)
    begin
        if (state_wr && phase_end)
        begin
            d_addr <= addr_step(d_addr, d_low, ctl_dalgn, ctl_asz, next_burst);
        end
        else
        begin
            if (wr_en[strb_daddr_l])
            begin
                d_addr[6:0] <= zdata[7:1];
                d_low[6:0]  <= zdata[7:1];
            end
            if (wr_en[strb_daddr_h])
            begin
                d_addr[12:7] <= zdata[5:0];
                d_low[7]     <= zdata[0];
            end
            if (wr_en[strb_daddr_x])
                d_addr[20:13] <= zdata;
        end
    end

endmodule

//--- verilog/dram_port.sv
// memory channel driver with a registered request stage
// read data is not stallable, so reads issue only against free read fifo space
`timescale 1ns/1ps

module dram_port
    import dma_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  dram_req_t             req_data,
    input  logic [fifo_cnt_w-1:0] rd_space,
    output logic                  mem_valid,
    input  logic                  mem_ready,
    output logic [addr_w-1:0]     mem_addr,
    output logic                  mem_we,
    output logic [data_w-1:0]     mem_wdata,
    input  logic                  mem_rvalid,
    input  logic [data_w-1:0]     mem_rdata,
    output logic                  rd_valid,
    output logic [data_w-1:0]     rd_data
);

    // reads taken into the stage and not yet pushed to the read fifo
    logic [fifo_cnt_w-1:0] rd_out;
    logic                  credit_ok;
    logic                  stage_free;
    logic                  req_xfer;
    logic                  rd_issue;

    assign credit_ok  = (rd_out < rd_space);
    assign stage_free = !mem_valid || mem_ready;
    assign req_ready  = stage_free && (req_data.we || credit_ok);
    assign req_xfer   = req_valid && req_ready;
    assign rd_issue   = req_xfer && !req_data.we;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            mem_valid <= 1'b0;
        else if (req_xfer)
            mem_valid <= 1'b1;
        else if (mem_ready)
            mem_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (req_xfer)
        begin
            mem_addr  <= req_data.addr;
            mem_we    <= req_data.we;
            mem_wdata <= req_data.wdata;
        end
    end

    // returned data goes one cycle later into the read fifo
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            rd_valid <= 1'b0;
        else
            rd_valid <= mem_rvalid;
        rd_data <= mem_rdata;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            rd_out <= '0;
        else if (rd_issue && !rd_valid)
            rd_out <= rd_out + 1'b1;
        else if (rd_valid && !rd_issue)
            rd_out <= rd_out - 1'b1;
    end

endmodule

//--- verilog/dma_fifo.sv
// small circular buffer, valid/ready on both sides
// a full fifo still takes a new entry in the cycle it hands one out
`timescale 1ns/1ps

module dma_fifo
    import dma_pkg::*;
#(
    parameter type payload_t = logic [data_w-1:0]
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    payload_t                mem [fifo_depth];
    logic [fifo_ptr_w-1:0]   wr_ptr;
    logic [fifo_ptr_w-1:0]   rd_ptr;
    logic [fifo_cnt_w-1:0]   count;
    logic                    push;
    logic                    pop;

    function automatic logic [fifo_ptr_w-1:0] ptr_next(input logic [fifo_ptr_w-1:0] ptr);
        return (ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign out_valid = (count != '0);
    assign in_ready  = (count != fifo_cnt_w'(fifo_depth)) || out_ready;
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

//--- verilog/dma_pkg.sv
// shared widths, device codes and strobe map of the dma engine
// only RAM, IDE and CRAM devices are supported

package dma_pkg;

    localparam int addr_w = 21;
    localparam int data_w = 16;

    // device codes from the control byte
    localparam logic [2:0] dev_ram  = 3'd1;
    localparam logic [2:0] dev_ide  = 3'd3;
    localparam logic [2:0] dev_cram = 3'd4;

    // control byte bits, device code sits in bits 2..0
    localparam int ctrl_wnr_bit   = 7;
    localparam int ctrl_salgn_bit = 5;
    localparam int ctrl_dalgn_bit = 4;
    localparam int ctrl_asz_bit   = 3;

    // cpu write strobes
    localparam int strb_saddr_l = 0;
    localparam int strb_saddr_h = 1;
    localparam int strb_saddr_x = 2;
    localparam int strb_daddr_l = 3;
    localparam int strb_daddr_h = 4;
    localparam int strb_daddr_x = 5;
    localparam int strb_len     = 6;
    localparam int strb_launch  = 7;
    localparam int strb_num     = 8;
    localparam int strb_cnt     = 9;

    localparam int fifo_depth = 2;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              we;
        logic [data_w-1:0] wdata;
    } dram_req_t;

endpackage
